/* mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// word address width, 64 words of scratchpad
`define MEM_ADDR_W 6

// data word width
`define MEM_DATA_W 32

// entries in each requester queue
`define MEM_REQ_DEPTH 4

// entries in the shared response queue
`define MEM_RSP_DEPTH 4

// number of requesters in front of the arbiter
`define MEM_NUM_PORTS 2

`endif

/* sched_pkg.sv */
`include "mem_params.svh"

package sched_pkg;

    // index of one requester
    // sized from the port count, one bit for two ports
    typedef logic [$clog2(`MEM_NUM_PORTS)-1:0] port_id_t;

    // arbitration result for the current cycle
    // valid high pops the queue named by port
    typedef struct packed {
        logic     valid;
        port_id_t port;
    } grant_t;

endpackage

/* bus_pkg.sv */
`include "mem_params.svh"

package bus_pkg;

    // requester index is shared with the arbiter side
    import sched_pkg::*;

    // one scratchpad access as a requester sees it
    typedef struct packed {
        // high for a write, low for a read
        logic                   we;
        // word address
        logic [`MEM_ADDR_W-1:0] addr;
        // write data, ignored on a read
        logic [`MEM_DATA_W-1:0] wdata;
    } mem_req_t;

    // one result as the consumer sees it
    typedef struct packed {
        // requester that issued the access
        port_id_t               port;
        // echoes the request kind
        logic                   we;
        // read data, zero for a write
        logic [`MEM_DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

/* fifo_v3.sv */
module fifo_v3 #(
    // number of entries, at least one
    parameter int unsigned DEPTH = 8,
    // payload type held in each entry
    parameter type dtype = logic,
    // pointer width, derived from the depth
    localparam int unsigned ADDR_DEPTH = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                  clk_i,
    input  logic                  rst,
    // drop every entry at the next edge
    input  logic                  flush_i,
    // level flags
    output logic                  full_o,
    output logic                  empty_o,
    output logic [ADDR_DEPTH-1:0] usage_o,
    // write side, push only while full_o is low
    input  dtype                  data_i,
    input  logic                  push_i,
    // read side, head is valid while empty_o is low
    output dtype                  data_o,
    input  logic                  pop_i
);

    // a zero depth queue is not supported
    if (DEPTH < 1) begin : g_depth_check
        $error("fifo_v3 needs DEPTH of at least one");
    end

    // read and write positions in the circular array
    logic [ADDR_DEPTH-1:0] read_pointer_q, read_pointer_n;
    logic [ADDR_DEPTH-1:0] write_pointer_q, write_pointer_n;

    // occupancy, one bit wider than the pointers so full is visible
    logic [ADDR_DEPTH:0] status_cnt_q, status_cnt_n;

    // storage
    dtype mem_q [DEPTH];

    // accepted strobes, illegal ones are ignored
    logic do_push;
    logic do_pop;

    assign full_o  = (status_cnt_q == (ADDR_DEPTH + 1)'(DEPTH));
    assign empty_o = (status_cnt_q == '0);

    // usage wraps to zero when the queue is full, full_o tells the two apart
    assign usage_o = status_cnt_q[ADDR_DEPTH-1:0];

    // head of the queue is always the registered entry
    assign data_o = mem_q[read_pointer_q];

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_comb begin : next_state
        read_pointer_n  = read_pointer_q;
        write_pointer_n = write_pointer_q;
        status_cnt_n    = status_cnt_q;

        if (do_push) begin
            // wrap at the last entry, depth need not be a power of two
            if (write_pointer_q == ADDR_DEPTH'(DEPTH - 1)) begin
                write_pointer_n = '0;
            end else begin
                write_pointer_n = write_pointer_q + 1'b1;
            end
        end

        if (do_pop) begin
            if (read_pointer_q == ADDR_DEPTH'(DEPTH - 1)) begin
                read_pointer_n = '0;
            end else begin
                read_pointer_n = read_pointer_q + 1'b1;
            end
        end

        // push and pop together keep the count
        if (do_push && !do_pop) begin
            status_cnt_n = status_cnt_q + 1'b1;
        end else if (do_pop && !do_push) begin
            status_cnt_n = status_cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i or posedge rst) begin
        if (rst) begin
            read_pointer_q  <= '0;
            write_pointer_q <= '0;
            status_cnt_q    <= '0;
        end else if (flush_i) begin
            // flush wins over any push or pop in the same cycle
            read_pointer_q  <= '0;
            write_pointer_q <= '0;
            status_cnt_q    <= '0;
        end else begin
            read_pointer_q  <= read_pointer_n;
            write_pointer_q <= write_pointer_n;
            status_cnt_q    <= status_cnt_n;
        end
    end

    // entry storage, written straight from the push strobe
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[write_pointer_q] <= data_i;
        end
    end

    // the producer outside must watch full_o
    full_write : assert property (
        @(posedge clk_i) disable iff (rst)
        full_o |-> !push_i
    ) else $error("push into a full queue");

    // the consumer outside must watch empty_o
    empty_read : assert property (
        @(posedge clk_i) disable iff (rst)
        empty_o |-> !pop_i
    ) else $error("pop from an empty queue");

endmodule

/* req_arbiter.sv */
`include "mem_params.svh"

module req_arbiter (
    input  logic                      clk_i,
    input  logic                      rst,
    // empty level of each request queue
    input  logic [`MEM_NUM_PORTS-1:0] req_empty_i,
    // response queue is full, hold everything
    input  logic                      stall_i,
    // port popped and executed this cycle
    output sched_pkg::grant_t         grant_o
);

    import sched_pkg::*;

    localparam int unsigned NUM_PORTS = `MEM_NUM_PORTS;

    // port with the highest priority next time
    port_id_t rr_q;
    port_id_t rr_n;

    // first non-empty port at or after the pointer
    always_comb begin : pick_port
        int unsigned idx;
        grant_o = '0;
        for (int unsigned i = 0; i < NUM_PORTS; i++) begin
            idx = rr_q + i;
            idx = idx % NUM_PORTS;
            if (!stall_i && !grant_o.valid && !req_empty_i[idx]) begin
                grant_o.valid = 1'b1;
                grant_o.port  = port_id_t'(idx);
            end
        end
    end

    // pointer goes one past the winner, wrapping after the last port
    assign rr_n = (grant_o.port == port_id_t'(NUM_PORTS - 1)) ? '0 : grant_o.port + 1'b1;

    always_ff @(posedge clk_i or posedge rst) begin
        if (rst) begin
            // port 0 is favoured out of reset
            rr_q <= '0;
        end else if (grant_o.valid) begin
            rr_q <= rr_n;
        end
    end

    // a grant pops its queue, so it must never name an empty one
    grant_not_empty : assert property (
        @(posedge clk_i) disable iff (rst)
        grant_o.valid |-> !req_empty_i[grant_o.port]
    ) else $error("grant to an empty request queue");

    // with every queue busy on two cycles in a row the winner changes
    rr_rotates : assert property (
        @(posedge clk_i) disable iff (rst)
        (grant_o.valid && req_empty_i == '0) ##1 (grant_o.valid && req_empty_i == '0)
        |-> grant_o.port != $past(grant_o.port)
    ) else $error("round-robin granted the same port twice under contention");

endmodule

/* scratchpad_mem.sv */
`include "mem_params.svh"

module scratchpad_mem (
    input  logic              clk_i,
    input  logic              rst,
    // granted port, valid means execute this cycle
    input  sched_pkg::grant_t grant_i,
    // request at the head of the granted queue
    input  bus_pkg::mem_req_t req_i,
    // response push into the response queue
    output logic              rsp_push_o,
    output bus_pkg::mem_rsp_t rsp_o
);

    import bus_pkg::*;

    localparam int unsigned WORDS = 2 ** `MEM_ADDR_W;

    // word array
    logic [`MEM_DATA_W-1:0] mem_q [WORDS];

    // every granted request produces exactly one response
    assign rsp_push_o = grant_i.valid;

    // response is formed from the word as it stands before the edge
    always_comb begin : form_rsp
        rsp_o.port  = grant_i.port;
        rsp_o.we    = req_i.we;
        // writes return zero data
        rsp_o.rdata = req_i.we ? '0 : mem_q[req_i.addr];
    end

    always_ff @(posedge clk_i or posedge rst) begin
        if (rst) begin
            // scratchpad starts all zero
            for (int unsigned w = 0; w < WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (grant_i.valid && req_i.we) begin
            mem_q[req_i.addr] <= req_i.wdata;
        end
    end

    // write then read of the same word on back-to-back grants sees the new data
    write_then_read : assert property (
        @(posedge clk_i) disable iff (rst)
        (rsp_push_o && req_i.we) ##1 (rsp_push_o && !req_i.we
            && req_i.addr == $past(req_i.addr))
        |-> rsp_o.rdata == $past(req_i.wdata)
    ) else $error("read did not return the word written one cycle before");

endmodule

/* mem_subsys_top.sv */
`include "mem_params.svh"

module mem_subsys_top (
    input  logic                      clk_i,
    input  logic                      rst,
    // empties all three queues, memory contents stay
    input  logic                      flush_i,
    // requester side, one queue per port
    input  logic [`MEM_NUM_PORTS-1:0] req_push_i,
    input  bus_pkg::mem_req_t         req_data_i [`MEM_NUM_PORTS],
    output logic [`MEM_NUM_PORTS-1:0] req_full_o,
    // consumer side
    input  logic                      rsp_pop_i,
    output logic                      rsp_empty_o,
    output bus_pkg::mem_rsp_t         rsp_data_o
);

    import sched_pkg::*;
    import bus_pkg::*;

    localparam int unsigned NUM_PORTS = `MEM_NUM_PORTS;

    // request queue status and heads
    logic [NUM_PORTS-1:0] req_empty;
    logic [NUM_PORTS-1:0] req_pop;
    mem_req_t             req_head [NUM_PORTS];

    // arbitration result
    grant_t grant;

    // head of the granted queue
    mem_req_t req_sel;

    // scratchpad into the response queue
    logic     rsp_push;
    mem_rsp_t rsp;
    logic     rsp_full;

    // one request queue per requester
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_req_fifo
        // pop only the queue that won this cycle
        assign req_pop[p] = grant.valid && (grant.port == port_id_t'(p));

        fifo_v3 #(
            .DEPTH (`MEM_REQ_DEPTH),
            .dtype (mem_req_t)
        ) u_req_fifo (
            .clk_i   (clk_i),
            .rst     (rst),
            .flush_i (flush_i),
            .full_o  (req_full_o[p]),
            .empty_o (req_empty[p]),
            .usage_o (),
            .data_i  (req_data_i[p]),
            .push_i  (req_push_i[p]),
            .data_o  (req_head[p]),
            .pop_i   (req_pop[p])
        );
    end

    // a full response queue stalls the arbiter
    req_arbiter u_req_arbiter (
        .clk_i       (clk_i),
        .rst         (rst),
        .req_empty_i (req_empty),
        .stall_i     (rsp_full),
        .grant_o     (grant)
    );

    // plain index by the granted port
    assign req_sel = req_head[grant.port];

    scratchpad_mem u_scratchpad_mem (
        .clk_i      (clk_i),
        .rst        (rst),
        .grant_i    (grant),
        .req_i      (req_sel),
        .rsp_push_o (rsp_push),
        .rsp_o      (rsp)
    );

    // shared response queue, drained by the consumer
    fifo_v3 #(
        .DEPTH (`MEM_RSP_DEPTH),
        .dtype (mem_rsp_t)
    ) u_rsp_fifo (
        .clk_i   (clk_i),
        .rst     (rst),
        .flush_i (flush_i),
        .full_o  (rsp_full),
        .empty_o (rsp_empty_o),
        .usage_o (),
        .data_i  (rsp),
        .push_i  (rsp_push),
        .data_o  (rsp_data_o),
        .pop_i   (rsp_pop_i)
    );

endmodule

/* tb_mem_subsys.sv */
`include "mem_params.svh"

module tb_mem_subsys;

    timeunit 1ns;
    timeprecision 100ps;

    import sched_pkg::*;
    import bus_pkg::*;

    localparam int WORDS = 2 ** `MEM_ADDR_W;
    // random requests issued per port
    localparam int RAND_PER_PORT = 40;
    // pushes per port that fill the response queue and then the request queue
    localparam int FILL_PER_PORT = `MEM_REQ_DEPTH + `MEM_RSP_DEPTH / `MEM_NUM_PORTS;
    // reset reads, write/read pairs, random, fill, flush sequence
    localparam int TOTAL_PUSHES = 4 + 4 + 2 * RAND_PER_PORT + 2 * FILL_PER_PORT
                                  + 4 + 2 * FILL_PER_PORT;
    localparam int CYCLE_LIMIT = 4 * TOTAL_PUSHES + 200;

    logic                      clk_i = 1'b0;
    logic                      rst;
    logic                      flush_i;
    logic [`MEM_NUM_PORTS-1:0] req_push_i;
    mem_req_t                  req_data_i [`MEM_NUM_PORTS];
    logic [`MEM_NUM_PORTS-1:0] req_full_o;
    logic                      rsp_pop_i = 1'b0;
    logic                      rsp_empty_o;
    mem_rsp_t                  rsp_data_o;

    // model memory, one image per port
    logic [`MEM_DATA_W-1:0] model_mem [`MEM_NUM_PORTS][WORDS];

    // expected responses in issue order, one queue per port
    mem_rsp_t exp_q0 [$];
    mem_rsp_t exp_q1 [$];

    logic [31:0] lcg_state = 32'd47734;
    int          cycle_cnt = 0;
    string       cur_test = "startup";

    // consumer control, changed on the rising edge only
    logic     consume_en = 1'b0;
    logic     alt_check = 1'b0;
    logic     have_last = 1'b0;
    port_id_t last_port;

    mem_subsys_top u_mem_subsys_top (
        .clk_i       (clk_i),
        .rst         (rst),
        .flush_i     (flush_i),
        .req_push_i  (req_push_i),
        .req_data_i  (req_data_i),
        .req_full_o  (req_full_o),
        .rsp_pop_i   (rsp_pop_i),
        .rsp_empty_o (rsp_empty_o),
        .rsp_data_o  (rsp_data_o)
    );

    // 20 ns period
    always #10 clk_i = ~clk_i;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [63:0] expv,
                               input logic [63:0] actv);
        if (expv !== actv) begin
            abort_run($sformatf("FAILED %s, %s: expected %0h, actual %0h",
                                cur_test, what, expv, actv));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic mem_req_t make_req(input logic we, input int addr,
                                          input logic [`MEM_DATA_W-1:0] wdata);
        mem_req_t req;
        req.we    = we;
        req.addr  = addr[`MEM_ADDR_W-1:0];
        req.wdata = wdata;
        return req;
    endfunction

    // port 0 stays in the lower half, port 1 in the upper half
    // only eight words per port so reads often hit earlier writes
    function automatic mem_req_t rand_req(input port_id_t p);
        logic [31:0] r;
        mem_req_t    req;
        r                       = lcg_next();
        req.we                  = r[24];
        req.addr                = '0;
        req.addr[2:0]           = r[18:16];
        req.addr[`MEM_ADDR_W-1] = p;
        req.wdata               = lcg_next();
        return req;
    endfunction

    // reference behavior of one access, updates the model image
    function automatic mem_rsp_t model_rsp(input port_id_t p, input mem_req_t req);
        mem_rsp_t rsp;
        rsp.port = p;
        rsp.we   = req.we;
        if (req.we) begin
            rsp.rdata               = '0;
            model_mem[p][req.addr] = req.wdata;
        end else begin
            rsp.rdata = model_mem[p][req.addr];
        end
        return rsp;
    endfunction

    task automatic expect_push(input port_id_t p, input mem_req_t req);
        if (p == 1'b0) begin
            exp_q0.push_back(model_rsp(p, req));
        end else begin
            exp_q1.push_back(model_rsp(p, req));
        end
    endtask

    // one cycle of requester activity, a port pushes only while not full
    task automatic step(input logic [1:0] en, input mem_req_t r0, input mem_req_t r1,
                        output logic [1:0] taken);
        taken         = en & ~req_full_o;
        req_data_i[0] = r0;
        req_data_i[1] = r1;
        req_push_i    = taken;
        if (taken[0]) begin
            expect_push(1'b0, r0);
        end
        if (taken[1]) begin
            expect_push(1'b1, r1);
        end
        @(negedge clk_i);
        req_push_i = '0;
    endtask

    task automatic push_one(input int p, input mem_req_t req);
        logic [1:0] taken;
        logic [1:0] en;
        en    = 2'b01 << p;
        taken = '0;
        while (!taken[p]) begin
            step(en, req, req, taken);
        end
    endtask

    task automatic begin_test(input string name, input logic consume, input logic alt);
        @(posedge clk_i);
        cur_test   = name;
        consume_en = consume;
        alt_check  = alt;
        have_last  = 1'b0;
        @(negedge clk_i);
    endtask

    task automatic set_consumer(input logic on);
        @(posedge clk_i);
        consume_en = on;
        @(negedge clk_i);
    endtask

    // wait until every expected response has been seen
    task automatic drain();
        while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            @(posedge clk_i);
        end
        @(negedge clk_i);
    endtask

    task automatic check_response(input mem_rsp_t act);
        mem_rsp_t expv;
        if (act.port == 1'b0 && exp_q0.size() == 0) begin
            abort_run($sformatf("%s: response from port 0 with no request outstanding",
                                cur_test));
        end else if (act.port == 1'b1 && exp_q1.size() == 0) begin
            abort_run($sformatf("%s: response from port 1 with no request outstanding",
                                cur_test));
        end else begin
            expv = (act.port == 1'b0) ? exp_q0.pop_front() : exp_q1.pop_front();
            check_value("response", expv, act);
        end
        // under contention the winner flips every grant
        if (alt_check && have_last) begin
            check_value("port alternation", !last_port, act.port);
        end
        last_port = act.port;
        have_last = 1'b1;
    endtask

    // consumer and compare, decides the pop and checks the head it removes
    always @(negedge clk_i) begin
        rsp_pop_i = 1'b0;
        if (!rst && consume_en && !rsp_empty_o) begin
            rsp_pop_i = 1'b1;
            check_response(rsp_data_o);
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            abort_run($sformatf("timeout, the tests did not finish within %0d cycles",
                                CYCLE_LIMIT));
        end
    end

    initial begin : stimulus
        logic [1:0]  taken;
        logic [1:0]  en;
        mem_req_t    r0;
        mem_req_t    r1;
        int          cnt0;
        int          cnt1;
        logic [31:0] rnd;

        rst           = 1'b1;
        flush_i       = 1'b0;
        req_push_i    = '0;
        req_data_i[0] = '0;
        req_data_i[1] = '0;
        for (int p = 0; p < `MEM_NUM_PORTS; p++) begin
            for (int w = 0; w < WORDS; w++) begin
                model_mem[p][w] = '0;
            end
        end
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst = 1'b0;

        // idle levels, then reads of the corner words
        begin_test("reset state", 1'b1, 1'b0);
        check_value("rsp_empty_o", 1, rsp_empty_o);
        check_value("req_full_o", 0, req_full_o);
        push_one(0, make_req(1'b0, 0, '0));
        push_one(0, make_req(1'b0, WORDS / 2 - 1, '0));
        push_one(1, make_req(1'b0, WORDS / 2, '0));
        push_one(1, make_req(1'b0, WORDS - 1, '0));
        drain();

        // back-to-back write and read on each port
        begin_test("write then read", 1'b1, 1'b0);
        push_one(0, make_req(1'b1, 5, 32'hcafe_0005));
        push_one(0, make_req(1'b0, 5, '0));
        push_one(1, make_req(1'b1, 40, 32'h1234_0028));
        push_one(1, make_req(1'b0, 40, '0));
        drain();

        begin_test("random traffic", 1'b1, 1'b0);
        cnt0 = 0;
        cnt1 = 0;
        r0   = rand_req(1'b0);
        r1   = rand_req(1'b1);
        while (cnt0 < RAND_PER_PORT || cnt1 < RAND_PER_PORT) begin
            rnd   = lcg_next();
            en[0] = (cnt0 < RAND_PER_PORT) && rnd[20];
            en[1] = (cnt1 < RAND_PER_PORT) && rnd[21];
            step(en, r0, r1, taken);
            if (taken[0]) begin
                cnt0 = cnt0 + 1;
                r0   = rand_req(1'b0);
            end
            if (taken[1]) begin
                cnt1 = cnt1 + 1;
                r1   = rand_req(1'b1);
            end
        end
        drain();

        // consumer stopped, response queue fills first, then both request queues
        begin_test("back-pressure", 1'b0, 1'b1);
        for (int i = 0; i < FILL_PER_PORT; i++) begin
            step(2'b11, rand_req(1'b0), rand_req(1'b1), taken);
            if (taken != 2'b11) begin
                abort_run("back-pressure: a request queue reported full too early");
            end
        end
        check_value("req_full_o when filled", 2'b11, req_full_o);
        check_value("rsp_empty_o when filled", 0, rsp_empty_o);
        set_consumer(1'b1);
        drain();

        // words written here must survive the flush
        begin_test("flush", 1'b1, 1'b0);
        push_one(0, make_req(1'b1, 20, 32'h5a5a_0014));
        push_one(1, make_req(1'b1, 50, 32'ha5a5_0032));
        drain();
        set_consumer(1'b0);
        // fill every queue so the flush has to clear all three
        for (int i = 0; i < FILL_PER_PORT; i++) begin
            step(2'b11, make_req(1'b0, 20, '0), make_req(1'b0, 50, '0), taken);
        end
        check_value("req_full_o before flush", 2'b11, req_full_o);
        check_value("rsp_empty_o before flush", 0, rsp_empty_o);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        check_value("rsp_empty_o after flush", 1, rsp_empty_o);
        check_value("req_full_o after flush", 0, req_full_o);
        // flushed reads never reach the consumer
        exp_q0.delete();
        exp_q1.delete();
        set_consumer(1'b1);
        push_one(0, make_req(1'b0, 20, '0));
        push_one(1, make_req(1'b0, 50, '0));
        drain();

        if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            abort_run("responses still missing at the end of the run");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

/* sim.f */
+incdir+.
sched_pkg.sv
bus_pkg.sv
fifo_v3.sv
req_arbiter.sv
scratchpad_mem.sv
mem_subsys_top.sv
tb_mem_subsys.sv
